/* include/gpu_defines.svh */
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// Register command fields
`define CMD_ADDR_W        7
`define CMD_DATA_W        32

// Video memory geometry, 1024 words of RGB565
`define VRAM_ADDR_W       10
`define PIXEL_W           16
`define LINE_WORDS        16

// FIFO sizing
`define CMD_FIFO_DEPTH    8
`define PIX_FIFO_DEPTH    16
`define CMD_ALMOST_FULL   6

// Register map
`define REG_MEM_ADDR      7'h00
`define REG_MEM_DATA      7'h01
`define REG_FILL_BASE     7'h02
`define REG_FILL_VALUE    7'h03
`define REG_FILL_COUNT    7'h04
`define REG_DISP_BASE     7'h05
`define REG_LINE_FETCH    7'h06
`define REG_STATUS        7'h07

`endif

/* design/gpu_cmd_pkg.sv */
`include "gpu_defines.svh"

package gpu_cmd_pkg;

    // =========================================================================
    // Host command path
    // =========================================================================

    // One register command as pushed by the host
    // rw set means a read
    typedef struct packed {
        logic                   rw;
        logic [`CMD_ADDR_W-1:0] addr;
        logic [`CMD_DATA_W-1:0] data;
    } cmd_t;

    // Readback word
    typedef struct packed {
        logic [`CMD_DATA_W-1:0] data;
    } rd_resp_t;

endpackage

/* design/gpu_mem_pkg.sv */
`include "gpu_defines.svh"

package gpu_mem_pkg;

    // =========================================================================
    // Video memory side
    // =========================================================================

    // RGB565 word, also the memory word
    typedef logic [`PIXEL_W-1:0] pixel_t;

    // Single-word access from one master
    typedef struct packed {
        logic                    we;
        logic [`VRAM_ADDR_W-1:0] addr;
        pixel_t                  wdata;
    } vram_req_t;

    // Arbiter slots, highest priority first
    typedef enum logic [1:0] {
        DISP = 2'd0,
        HOST = 2'd1,
        FILL = 2'd2
    } master_e;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8,
    parameter int  AF_LEVEL  = 6
) (
    input  logic     clk_core,
    input  logic     rst_n_core,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full,
    output logic     almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head entry always visible
    assign dout        = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (count >= CNT_W'(AF_LEVEL));

    // Storage
    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Producer and consumer both honour the flags
    a_no_overflow_underflow: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        !(push && full) && !(pop && empty)
    );

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module register_file (
    input  logic                    clk_core,
    input  logic                    rst_n_core,
    input  logic                    cmd_empty,
    input  gpu_cmd_pkg::cmd_t       cmd_head,
    output logic                    cmd_pop,
    output logic                    rd_valid,
    output gpu_cmd_pkg::rd_resp_t   rd_resp,
    input  logic                    fill_busy,
    output logic                    fill_start,
    output logic [`VRAM_ADDR_W-1:0] fill_base,
    output gpu_mem_pkg::pixel_t     fill_value,
    output logic [`VRAM_ADDR_W:0]   fill_count,
    output logic                    line_start,
    output logic [`VRAM_ADDR_W-1:0] line_index,
    output logic [`VRAM_ADDR_W-1:0] disp_base,
    output logic                    host_req,
    output gpu_mem_pkg::vram_req_t  host_bus,
    input  logic                    host_ack
);

    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    logic [`VRAM_ADDR_W-1:0] mem_addr;
    logic                    wr_en;
    logic [`CMD_DATA_W-1:0]  rd_data;

    // Stall while a fill starts or runs, or while a host write is in flight
    assign cmd_pop = !cmd_empty && !fill_busy && !fill_start && !host_req && !host_ack;
    assign wr_en   = cmd_pop && !cmd_head.rw;

    // Readback mux, MEM_DATA is write-only
    always_comb begin
        rd_data = '0;
        case (cmd_head.addr)
            `REG_MEM_ADDR:   rd_data = 32'(mem_addr);
            `REG_FILL_BASE:  rd_data = 32'(fill_base);
            `REG_FILL_VALUE: rd_data = 32'(fill_value);
            `REG_FILL_COUNT: rd_data = 32'(fill_count);
            `REG_DISP_BASE:  rd_data = 32'(disp_base);
            `REG_LINE_FETCH: rd_data = 32'(line_index);
            `REG_STATUS:     rd_data[0] = fill_busy;
            default:         rd_data = '0;
        endcase
    end

    // =========================================================================
    // Configuration registers and trigger pulses
    // =========================================================================

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            mem_addr   <= '0;
            fill_base  <= '0;
            fill_value <= '0;
            fill_count <= '0;
            disp_base  <= '0;
            line_index <= '0;
            fill_start <= 1'b0;
            line_start <= 1'b0;
            rd_valid   <= 1'b0;
            host_req   <= 1'b0;
        end else begin
            // Single-cycle strobes
            fill_start <= 1'b0;
            line_start <= 1'b0;
            rd_valid   <= cmd_pop && cmd_head.rw;
            // Host link, drop req once the arbiter answers
            if (host_req && host_ack) begin
                host_req <= 1'b0;
            end
            if (wr_en) begin
                case (cmd_head.addr)
                    `REG_MEM_ADDR:   mem_addr   <= cmd_head.data[`VRAM_ADDR_W-1:0];
                    `REG_MEM_DATA:   host_req   <= 1'b1;
                    `REG_FILL_BASE:  fill_base  <= cmd_head.data[`VRAM_ADDR_W-1:0];
                    `REG_FILL_VALUE: fill_value <= cmd_head.data[`PIXEL_W-1:0];
                    `REG_FILL_COUNT: begin
                        // Writing the count kicks off the fill
                        fill_count <= cmd_head.data[`VRAM_ADDR_W:0];
                        fill_start <= 1'b1;
                    end
                    `REG_DISP_BASE:  disp_base  <= cmd_head.data[`VRAM_ADDR_W-1:0];
                    `REG_LINE_FETCH: begin
                        line_index <= cmd_head.data[`VRAM_ADDR_W-1:0];
                        line_start <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data and host write word
    always_ff @(posedge clk_core) begin
        if (cmd_pop && cmd_head.rw) begin
            rd_resp <= rd_resp_t'{data: rd_data};
        end
        if (wr_en && cmd_head.addr == `REG_MEM_DATA) begin
            host_bus <= vram_req_t'{we: 1'b1, addr: mem_addr,
                                    wdata: cmd_head.data[`PIXEL_W-1:0]};
        end
    end

endmodule

/* design/fill_engine.sv */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module fill_engine (
    input  logic                    clk_core,
    input  logic                    rst_n_core,
    input  logic                    fill_start,
    input  logic [`VRAM_ADDR_W-1:0] fill_base,
    input  gpu_mem_pkg::pixel_t     fill_value,
    input  logic [`VRAM_ADDR_W:0]   fill_count,
    output logic                    fill_busy,
    output logic                    req,
    output gpu_mem_pkg::vram_req_t  bus,
    input  logic                    ack
);

    import gpu_mem_pkg::*;

    // Word being written and words still to go
    logic [`VRAM_ADDR_W-1:0] cur_addr;
    logic [`VRAM_ADDR_W:0]   remaining;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            fill_busy <= 1'b0;
            req       <= 1'b0;
            cur_addr  <= '0;
            remaining <= '0;
        end else if (!fill_busy) begin
            // Zero count is a no-op
            if (fill_start && fill_count != '0) begin
                fill_busy <= 1'b1;
                cur_addr  <= fill_base;
                remaining <= fill_count;
            end
        end else if (req && ack) begin
            // Word done, release the link
            req       <= 1'b0;
            cur_addr  <= cur_addr + 1'b1;
            remaining <= remaining - 1'b1;
        end else if (!req && !ack) begin
            // Link idle again
            if (remaining == '0) begin
                fill_busy <= 1'b0;
            end else begin
                req <= 1'b1;
            end
        end
    end

    // Address wraps at top of memory through the counter width
    assign bus = vram_req_t'{we: 1'b1, addr: cur_addr, wdata: fill_value};

    // Request held steady until the arbiter answers
    a_req_stable: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        (req && !ack) |=> (req && $stable(bus))
    );

endmodule

/* design/scanline_fetch.sv */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module scanline_fetch (
    input  logic                    clk_core,
    input  logic                    rst_n_core,
    input  logic                    line_start,
    input  logic [`VRAM_ADDR_W-1:0] line_index,
    input  logic [`VRAM_ADDR_W-1:0] disp_base,
    output logic                    req,
    output gpu_mem_pkg::vram_req_t  bus,
    input  logic                    ack,
    input  gpu_mem_pkg::pixel_t     rdata,
    output logic                    pix_push,
    output gpu_mem_pkg::pixel_t     pix_data,
    input  logic                    pix_full
);

    import gpu_mem_pkg::*;

    localparam int LINE_SHIFT = $clog2(`LINE_WORDS);
    localparam int CNT_W      = $clog2(`LINE_WORDS + 1);

    logic                    active;
    logic [`VRAM_ADDR_W-1:0] cur_addr;
    logic [CNT_W-1:0]        remaining;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            active    <= 1'b0;
            req       <= 1'b0;
            cur_addr  <= '0;
            remaining <= '0;
        end else if (!active) begin
            // New line request is ignored while one is in progress
            if (line_start) begin
                active    <= 1'b1;
                cur_addr  <= disp_base + (line_index << LINE_SHIFT);
                remaining <= CNT_W'(`LINE_WORDS);
            end
        end else if (req && ack) begin
            req       <= 1'b0;
            cur_addr  <= cur_addr + 1'b1;
            remaining <= remaining - 1'b1;
        end else if (!req && !ack) begin
            if (remaining == '0) begin
                active <= 1'b0;
            end else if (!pix_full) begin
                // Only this block pushes, so a free slot stays free until ack
                req <= 1'b1;
            end
        end
    end

    // Read-only requests
    assign bus = vram_req_t'{we: 1'b0, addr: cur_addr, wdata: '0};

    // Pixel goes into the FIFO with its ack
    assign pix_push = req && ack;
    assign pix_data = rdata;

endmodule

/* design/vram_arbiter.sv */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module vram_arbiter (
    input  logic                   clk_core,
    input  logic                   rst_n_core,
    input  logic                   disp_req,
    input  gpu_mem_pkg::vram_req_t disp_bus,
    output logic                   disp_ack,
    input  logic                   host_req,
    input  gpu_mem_pkg::vram_req_t host_bus,
    output logic                   host_ack,
    input  logic                   fill_req,
    input  gpu_mem_pkg::vram_req_t fill_bus,
    output logic                   fill_ack,
    output gpu_mem_pkg::pixel_t    rdata
);

    import gpu_mem_pkg::*;

    localparam int WORDS = 1 << `VRAM_ADDR_W;

    pixel_t    mem [WORDS];
    logic [2:0] req_vec;
    logic [2:0] ack_q;
    master_e    win;
    vram_req_t  sel_bus;
    logic       grant_now;

    // Bit position follows master_e
    assign req_vec = {fill_req, host_req, disp_req};

    // =========================================================================
    // Fixed priority pick
    // =========================================================================

    always_comb begin
        if (disp_req) begin
            win     = DISP;
            sel_bus = disp_bus;
        end else if (host_req) begin
            win     = HOST;
            sel_bus = host_bus;
        end else begin
            win     = FILL;
            sel_bus = fill_bus;
        end
    end

    // New grant only once every ack is low
    assign grant_now = (ack_q == '0) && (req_vec != '0);

    // Grant lock and four-phase ack
    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            ack_q <= '0;
        end else if (grant_now) begin
            ack_q <= 3'b001 << win;
        end else if ((req_vec & ack_q) == '0) begin
            // Granted master let go
            ack_q <= '0;
        end
    end

    // Access happens on the grant edge and data comes with ack
    always_ff @(posedge clk_core) begin
        if (grant_now) begin
            if (sel_bus.we) begin
                mem[sel_bus.addr] <= sel_bus.wdata;
            end
            rdata <= mem[sel_bus.addr];
        end
    end

    assign disp_ack = ack_q[DISP];
    assign host_ack = ack_q[HOST];
    assign fill_ack = ack_q[FILL];

    // At most one master served at a time and no master drops req before its ack
    a_ack_onehot: assert property (
        @(posedge clk_core) disable iff (!rst_n_core)
        $onehot0({disp_ack, host_ack, fill_ack})
        && ((~req_vec & $past(req_vec) & ~$past(ack_q)) == '0)
    );

endmodule

/* design/gpu_core_top.sv */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module gpu_core_top (
    input  logic                  clk_core,
    input  logic                  rst_n_core,
    input  logic                  cmd_req,
    input  gpu_cmd_pkg::cmd_t     cmd,
    output logic                  cmd_ack,
    output logic                  rd_valid,
    output gpu_cmd_pkg::rd_resp_t rd_resp,
    output logic                  pix_valid,
    output gpu_mem_pkg::pixel_t   pix,
    input  logic                  pix_ready,
    output logic                  cmd_empty,
    output logic                  cmd_almost_full,
    output logic                  busy
);

    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    // Command path
    cmd_t cmd_head;
    logic cmd_push;
    logic cmd_full;
    logic cmd_pop;

    // Register file outputs
    logic                    fill_start;
    logic                    fill_busy;
    logic [`VRAM_ADDR_W-1:0] fill_base;
    pixel_t                  fill_value;
    logic [`VRAM_ADDR_W:0]   fill_count;
    logic                    line_start;
    logic [`VRAM_ADDR_W-1:0] line_index;
    logic [`VRAM_ADDR_W-1:0] disp_base;

    // Arbiter links
    logic      disp_req;
    logic      disp_ack;
    vram_req_t disp_bus;
    logic      host_req;
    logic      host_ack;
    vram_req_t host_bus;
    logic      fill_req;
    logic      fill_ack;
    vram_req_t fill_bus;
    pixel_t    vram_rdata;

    // Pixel path
    logic   pix_push;
    pixel_t pix_data;
    logic   pix_full;
    logic   pix_empty;

    // =========================================================================
    // Host command handshake
    // =========================================================================

    // Push on the edge that raises ack, full FIFO holds ack back
    assign cmd_push = cmd_req && !cmd_ack && !cmd_full;

    always_ff @(posedge clk_core or negedge rst_n_core) begin
        if (!rst_n_core) begin
            cmd_ack <= 1'b0;
        end else if (cmd_push) begin
            cmd_ack <= 1'b1;
        end else if (cmd_ack && !cmd_req) begin
            cmd_ack <= 1'b0;
        end
    end

    sync_fifo #(
        .payload_t (cmd_t),
        .DEPTH     (`CMD_FIFO_DEPTH),
        .AF_LEVEL  (`CMD_ALMOST_FULL)
    ) u_cmd_fifo (
        .clk_core    (clk_core),
        .rst_n_core  (rst_n_core),
        .push        (cmd_push),
        .din         (cmd),
        .pop         (cmd_pop),
        .dout        (cmd_head),
        .empty       (cmd_empty),
        .full        (cmd_full),
        .almost_full (cmd_almost_full)
    );

    register_file u_register_file (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .cmd_empty  (cmd_empty),
        .cmd_head   (cmd_head),
        .cmd_pop    (cmd_pop),
        .rd_valid   (rd_valid),
        .rd_resp    (rd_resp),
        .fill_busy  (fill_busy),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_value (fill_value),
        .fill_count (fill_count),
        .line_start (line_start),
        .line_index (line_index),
        .disp_base  (disp_base),
        .host_req   (host_req),
        .host_bus   (host_bus),
        .host_ack   (host_ack)
    );

    // =========================================================================
    // Memory masters and shared RAM
    // =========================================================================

    fill_engine u_fill_engine (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .fill_value (fill_value),
        .fill_count (fill_count),
        .fill_busy  (fill_busy),
        .req        (fill_req),
        .bus        (fill_bus),
        .ack        (fill_ack)
    );

    scanline_fetch u_scanline_fetch (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .line_start (line_start),
        .line_index (line_index),
        .disp_base  (disp_base),
        .req        (disp_req),
        .bus        (disp_bus),
        .ack        (disp_ack),
        .rdata      (vram_rdata),
        .pix_push   (pix_push),
        .pix_data   (pix_data),
        .pix_full   (pix_full)
    );

    vram_arbiter u_vram_arbiter (
        .clk_core   (clk_core),
        .rst_n_core (rst_n_core),
        .disp_req   (disp_req),
        .disp_bus   (disp_bus),
        .disp_ack   (disp_ack),
        .host_req   (host_req),
        .host_bus   (host_bus),
        .host_ack   (host_ack),
        .fill_req   (fill_req),
        .fill_bus   (fill_bus),
        .fill_ack   (fill_ack),
        .rdata      (vram_rdata)
    );

    // Pixel stream out of the FIFO
    sync_fifo #(
        .payload_t (pixel_t),
        .DEPTH     (`PIX_FIFO_DEPTH),
        .AF_LEVEL  (`PIX_FIFO_DEPTH)
    ) u_pix_fifo (
        .clk_core    (clk_core),
        .rst_n_core  (rst_n_core),
        .push        (pix_push),
        .din         (pix_data),
        .pop         (pix_valid && pix_ready),
        .dout        (pix),
        .empty       (pix_empty),
        .full        (pix_full),
        .almost_full ()
    );

    assign pix_valid = !pix_empty;
    assign busy      = fill_busy;

endmodule

/* tests/tb_gpu_core.sv */
`timescale 1ns/1ps
`include "gpu_defines.svh"

module tb_gpu_core;

    import gpu_cmd_pkg::*;
    import gpu_mem_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int AW          = `VRAM_ADDR_W;
    localparam int LINE        = `LINE_WORDS;
    localparam int ACK_TIMEOUT = 10000;
    localparam int RD_TIMEOUT  = 10000;
    localparam int PIX_TIMEOUT = 2000;
    // About 1040 fill words at 4 cycles each, 130 commands and 8 lines, times four
    localparam int WATCHDOG_CYCLES = 25000;

    logic     clk_core = 1'b0;
    logic     rst_n_core;
    logic     cmd_req;
    cmd_t     cmd;
    logic     cmd_ack;
    logic     rd_valid;
    rd_resp_t rd_resp;
    logic     pix_valid;
    pixel_t   pix;
    logic     pix_ready;
    logic     cmd_empty;
    logic     cmd_almost_full;
    logic     busy;

    // Reference memory, only words written here get compared
    pixel_t model_mem [1 << `VRAM_ADDR_W];
    bit     model_ok  [1 << `VRAM_ADDR_W];
    int     cur_disp_base;

    // Captured responses and how far the tests have consumed them
    logic [31:0] rd_q [$];
    pixel_t      pix_q [$];
    int          rd_seen;
    int          pix_seen;

    int     errors;
    int     checks;
    int     max_ack_wait;
    integer seed;

    gpu_core_top dut0 (
        .clk_core        (clk_core),
        .rst_n_core      (rst_n_core),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .cmd_ack         (cmd_ack),
        .rd_valid        (rd_valid),
        .rd_resp         (rd_resp),
        .pix_valid       (pix_valid),
        .pix             (pix),
        .pix_ready       (pix_ready),
        .cmd_empty       (cmd_empty),
        .cmd_almost_full (cmd_almost_full),
        .busy            (busy)
    );

    always #(CLK_PERIOD / 2) clk_core = ~clk_core;

    // Pre-edge values, the same ones the DUT acts on
    always @(posedge clk_core) begin
        if (rd_valid) begin
            rd_q.push_back(rd_resp.data);
        end
        if (pix_valid && pix_ready) begin
            pix_q.push_back(pix);
        end
    end

    // =========================================================================
    // Checking and bus helpers
    // =========================================================================

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks = checks + 1;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected=%08h actual=%08h", $time, name, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR t=%0t %s", $time, what);
        errors = errors + 1;
    endtask

    // Unique word per address
    function automatic pixel_t host_pattern(input logic [AW-1:0] a);
        return 16'(a) * 16'd97 + 16'h1357;
    endfunction

    // Four-phase push into the command FIFO
    task automatic send_cmd(input logic rw, input logic [6:0] addr, input logic [31:0] data);
        int waited;
        @(negedge clk_core);
        cmd.rw   = rw;
        cmd.addr = addr;
        cmd.data = data;
        cmd_req  = 1'b1;
        @(negedge clk_core);
        waited = 1;
        while (!cmd_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk_core);
            waited = waited + 1;
        end
        assert (cmd_ack) else report_problem("cmd_ack never rose for a queued command");
        if (waited > max_ack_wait) begin
            max_ack_wait = waited;
        end
        cmd_req = 1'b0;
        waited  = 0;
        while (cmd_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk_core);
            waited = waited + 1;
        end
        assert (!cmd_ack) else report_problem("cmd_ack stayed high after cmd_req fell");
    endtask

    task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
        send_cmd(1'b0, addr, data);
    endtask

    task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
        int waited;
        send_cmd(1'b1, addr, 32'h0);
        waited = 0;
        while (rd_q.size() <= rd_seen && waited < RD_TIMEOUT) begin
            @(negedge clk_core);
            waited = waited + 1;
        end
        assert (rd_q.size() > rd_seen) else report_problem("no rd_valid came back for a read");
        data = (rd_q.size() > rd_seen) ? rd_q[rd_seen] : 32'hFFFF_FFFF;
        rd_seen = rd_q.size();
    endtask

    task automatic check_reg(input string name, input logic [6:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        read_reg(addr, got);
        check_value(name, exp, got);
    endtask

    task automatic host_write(input logic [AW-1:0] addr, input pixel_t value);
        write_reg(`REG_MEM_ADDR, 32'(addr));
        write_reg(`REG_MEM_DATA, 32'(value));
        model_mem[addr] = value;
        model_ok[addr]  = 1'b1;
    endtask

    // Count register goes last, it triggers the engine
    task automatic start_fill(input int base, input pixel_t value, input int count);
        int            i;
        logic [AW-1:0] a;
        write_reg(`REG_FILL_BASE, base);
        write_reg(`REG_FILL_VALUE, 32'(value));
        write_reg(`REG_FILL_COUNT, count);
        for (i = 0; i < count; i++) begin
            a = AW'(base + i);
            model_mem[a] = value;
            model_ok[a]  = 1'b1;
        end
    endtask

    task automatic set_disp_base(input int base);
        write_reg(`REG_DISP_BASE, base);
        cur_disp_base = base;
    endtask

    // Status read pops only after the fill, so its answer marks the end
    task automatic check_idle();
        check_reg("status", `REG_STATUS, 32'h0);
        check_value("cmd_empty", 32'd1, 32'(cmd_empty));
        check_value("busy", 32'd0, 32'(busy));
    endtask

    task automatic fetch_line(input int index, input bit random_ready);
        int            waited;
        int            rnd;
        int            i;
        logic [AW-1:0] a;
        write_reg(`REG_LINE_FETCH, index);
        waited = 0;
        while (pix_q.size() < pix_seen + LINE && waited < PIX_TIMEOUT) begin
            @(negedge clk_core);
            if (random_ready) begin
                rnd       = $random(seed);
                pix_ready = rnd[0];
            end
            waited = waited + 1;
        end
        pix_ready = 1'b1;
        assert (pix_q.size() >= pix_seen + LINE) else begin
            report_problem($sformatf("line %0d stopped after %0d pixels", index,
                                     pix_q.size() - pix_seen));
        end
        if (pix_q.size() >= pix_seen + LINE) begin
            for (i = 0; i < LINE; i++) begin
                a = AW'(cur_disp_base + index * LINE + i);
                if (model_ok[a]) begin
                    check_value($sformatf("pix word %0d", a), 32'(model_mem[a]),
                                32'(pix_q[pix_seen + i]));
                end
            end
            pix_seen = pix_seen + LINE;
            // Nothing extra may trail the line
            repeat (LINE) @(negedge clk_core);
            check_value("pixel count", 32'(pix_seen), 32'(pix_q.size()));
        end
        pix_seen = pix_q.size();
    endtask

    // =========================================================================
    // Directed tests
    // =========================================================================

    task automatic check_reset_state();
        check_value("cmd_ack", 32'd0, 32'(cmd_ack));
        check_value("rd_valid", 32'd0, 32'(rd_valid));
        check_value("pix_valid", 32'd0, 32'(pix_valid));
        check_value("busy", 32'd0, 32'(busy));
        check_value("cmd_empty", 32'd1, 32'(cmd_empty));
    endtask

    task automatic register_readback();
        logic [31:0] addr_mask;
        logic [31:0] pix_mask;
        addr_mask = (32'd1 << AW) - 32'd1;
        pix_mask  = (32'd1 << `PIXEL_W) - 32'd1;
        write_reg(`REG_MEM_ADDR, 32'h0000_0AB3);
        write_reg(`REG_FILL_BASE, 32'h0000_0155);
        write_reg(`REG_FILL_VALUE, 32'hDEAD_BEEF);
        write_reg(`REG_DISP_BASE, 32'h0000_F040);
        // Registers keep only their low bits
        check_reg("mem_addr", `REG_MEM_ADDR, 32'h0000_0AB3 & addr_mask);
        check_reg("fill_base", `REG_FILL_BASE, 32'h0000_0155 & addr_mask);
        check_reg("fill_value", `REG_FILL_VALUE, 32'hDEAD_BEEF & pix_mask);
        check_reg("disp_base", `REG_DISP_BASE, 32'h0000_F040 & addr_mask);
        check_reg("status", `REG_STATUS, 32'h0);
    endtask

    task automatic host_write_line();
        int i;
        set_disp_base(0);
        for (i = 6 * LINE; i < 7 * LINE; i++) begin
            host_write(AW'(i), host_pattern(AW'(i)));
        end
        fetch_line(6, 1'b0);
    endtask

    // Words 96 to 143 host written, 100 to 139 then filled
    task automatic fill_and_verify();
        int i;
        for (i = 7 * LINE; i < 9 * LINE; i++) begin
            host_write(AW'(i), host_pattern(AW'(i)));
        end
        start_fill(100, 16'h1234, 40);
        check_idle();
        fetch_line(6, 1'b0);
        fetch_line(7, 1'b0);
        fetch_line(8, 1'b0);
    endtask

    task automatic pixel_backpressure();
        fetch_line(6, 1'b1);
        fetch_line(8, 1'b1);
    endtask

    task automatic cmd_backpressure();
        logic [AW-1:0] wr_addr [5];
        pixel_t        wr_data [5];
        bit            af_seen;
        int            i;
        wr_addr      = '{10'd176, 10'd177, 10'd178, 10'd176, 10'd205};
        wr_data      = '{16'hA001, 16'hA002, 16'hA003, 16'hCAFE, 16'hBEEF};
        af_seen      = 1'b0;
        max_ack_wait = 0;
        // Wraps past the top, 200 to 1023 then 0 to 175
        start_fill(200, 16'h5A5A, 1000);
        // Ten writes pile up behind the fill, a repeat address shows the order
        for (i = 0; i < 5; i++) begin
            host_write(wr_addr[i], wr_data[i]);
            if (cmd_almost_full) begin
                af_seen = 1'b1;
            end
        end
        assert (af_seen) else report_problem("cmd_almost_full never rose behind the long fill");
        assert (max_ack_wait > 1) else report_problem("cmd_ack never stalled on a full FIFO");
        check_idle();
        fetch_line(11, 1'b0);
        fetch_line(12, 1'b0);
    endtask

    // =========================================================================
    // Sequence and watchdog
    // =========================================================================

    initial begin
        seed          = 41;
        errors        = 0;
        checks        = 0;
        rd_seen       = 0;
        pix_seen      = 0;
        max_ack_wait  = 0;
        cur_disp_base = 0;
        rst_n_core    = 1'b0;
        cmd_req       = 1'b0;
        cmd           = '0;
        pix_ready     = 1'b1;
        repeat (8) @(posedge clk_core);
        @(negedge clk_core);
        rst_n_core = 1'b1;
        @(negedge clk_core);
        check_reset_state();
        register_readback();
        host_write_line();
        fill_and_verify();
        pixel_backpressure();
        cmd_backpressure();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR watchdog expired after %0d cycles with tests unfinished",
                 WATCHDOG_CYCLES);
        $display("Summary: %0d checks, %0d errors", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
design/gpu_cmd_pkg.sv
design/gpu_mem_pkg.sv
design/sync_fifo.sv
design/register_file.sv
design/fill_engine.sv
design/scanline_fetch.sv
design/vram_arbiter.sv
design/gpu_core_top.sv
tests/tb_gpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_gpu_core --Mdir obj_dir -j 0
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_gpu_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
